// File: bench/rvCoreTb.sv
/*
 * rvCore testbench
 * runs small directed RV32I programs and checks the stores they make
 */
`timescale 1ns/100ps
`include "rvCore_defines.svh"

module rvCoreTb;

	localparam logic [6:0] opImmCode = 7'b0010011;
	localparam logic [6:0] loadCode = 7'b0000011;
	localparam logic [31:0] sentinelAddr = 32'h0000_03FC;
	localparam int timeoutCycles = 500;

	logic clk;
	logic rst;
	logic [31:0] imemData;
	logic [31:0] dmemRdata;
	logic [31:0] imemAddr;
	logic [31:0] dmemAddr;
	logic [31:0] dmemWdata;
	logic dmemWe;

	// word-addressed memories, 1 KiB each
	logic [31:0] imem [256];
	logic [31:0] dmem [256];

	// every store the core makes, oldest first
	logic [31:0] storeAddr [$];
	logic [31:0] storeData [$];
	int logStart;
	int progLen;
	int errors;
	int checks;

	rvCore DUT (
		.clk(clk),
		.rst(rst),
		.imemData(imemData),
		.dmemRdata(dmemRdata),
		.imemAddr(imemAddr),
		.dmemAddr(dmemAddr),
		.dmemWdata(dmemWdata),
		.dmemWe(dmemWe)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// background data pattern, unique per word address
	function automatic logic [31:0] fillWord(input logic [7:0] idx);
		return {8'hD0, ~idx, 8'h5A, idx};
	endfunction

	assign imemData = imem[imemAddr[9:2]];
	assign dmemRdata = dmem[dmemAddr[9:2]];

	// data memory refills while in reset, otherwise writes and logs stores
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 256; i++)
				dmem[i[7:0]] <= fillWord(i[7:0]);
		end else if (dmemWe) begin
			dmem[dmemAddr[9:2]] <= dmemWdata;
			storeAddr.push_back(dmemAddr);
			storeData.push_back(dmemWdata);
		end
	end

	// RV32I instruction formats
	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	// sw rs2, imm(rs1)
	function automatic logic [31:0] encS(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// beq rs1, rs2, off
	function automatic logic [31:0] encB(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] sx12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [11:0] rand12();
		logic [31:0] r;
		r = $urandom();
		return r[11:0];
	endfunction

	function automatic int countStores(input logic [31:0] addr);
		int n;
		n = 0;
		for (int i = logStart; i < storeAddr.size(); i++)
			if (storeAddr[i] == addr)
				n++;
		return n;
	endfunction

	// program image, padded with nops
	task automatic clearProgram();
		for (int i = 0; i < 256; i++)
			imem[i[7:0]] = `RV_NOP;
		progLen = 0;
	endtask

	task automatic emit(input logic [31:0] word);
		imem[progLen[7:0]] = word;
		progLen++;
	endtask

	// end marker store, then spin in place
	task automatic endProgram();
		emit(encS(5'd0, 5'd0, sentinelAddr[11:0]));
		emit(encJ(5'd0, 21'd0));
	endtask

	task automatic assertReset();
		@(negedge clk);
		rst = 1'b1;
	endtask

	// keeps reset for 4 cycles, then checks the first cycle out of reset
	task automatic releaseReset();
		repeat (4) @(negedge clk);
		logStart = storeAddr.size();
		rst = 1'b0;
		#1;
		checks++;
		assert (imemAddr == `RV_RESET_PC && !dmemWe) else begin
			errors++;
			$display("[ERROR] %0t: after reset imemAddr=0x%h dmemWe=%b", $time, imemAddr,
				dmemWe);
		end
	endtask

	task automatic waitForStoreCount(input logic [31:0] addr, input int count,
		input string what);
		int cycles;
		int n;
		cycles = 0;
		n = 0;
		while (n < count && cycles < timeoutCycles) begin
			@(negedge clk);
			cycles++;
			n = countStores(addr);
		end
		if (n < count) begin
			errors++;
			$display("timed out waiting for the stores of the %s test", what);
		end
	endtask

	// checks the most recent store to an address
	task automatic expectStore(input logic [31:0] addr, input logic [31:0] expected);
		logic found;
		logic [31:0] value;
		found = 1'b0;
		value = '0;
		for (int i = logStart; i < storeAddr.size(); i++) begin
			if (storeAddr[i] == addr) begin
				found = 1'b1;
				value = storeData[i];
			end
		end
		checks++;
		assert (found) else begin
			errors++;
			$display("no store to address 0x%h was seen", addr);
		end
		if (found) begin
			checks++;
			assert (value == expected) else begin
				errors++;
				$display("[ERROR] %0t: store to 0x%h wrote 0x%h, expected 0x%h", $time, addr,
					value, expected);
			end
		end
	endtask

	task automatic expectNoStore(input logic [31:0] addr);
		int n;
		n = countStores(addr);
		checks++;
		assert (n == 0) else begin
			errors++;
			$display("a store to 0x%h should never have happened but was seen %0d times",
				addr, n);
		end
	endtask

	// restart in the middle of an endless store loop
	task automatic testReset();
		logic [11:0] r;
		r = rand12();
		assertReset();
		clearProgram();
		emit(encI(3'b000, 5'd1, 5'd0, 12'd1, opImmCode));
		emit(encS(5'd1, 5'd0, 12'h200));
		emit(encI(3'b000, 5'd1, 5'd1, 12'd1, opImmCode));
		emit(encJ(5'd0, 21'h1FFFF8));
		releaseReset();
		waitForStoreCount(32'h200, 3, "store loop");
		assertReset();
		clearProgram();
		// a leading store shows up on dmemWe if reset left execute loaded
		emit(encS(5'd0, 5'd0, 12'h208));
		emit(encI(3'b000, 5'd2, 5'd0, r, opImmCode));
		emit(encS(5'd2, 5'd0, 12'h204));
		endProgram();
		releaseReset();
		waitForStoreCount(sentinelAddr, 1, "reset");
		expectNoStore(32'h200);
		expectStore(32'h208, 32'd0);
		expectStore(32'h204, sx12(r));
	endtask

	task automatic testArith();
		logic [11:0] a;
		logic [11:0] b;
		logic [11:0] c;
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] vc;
		a = rand12();
		b = rand12();
		c = rand12();
		va = sx12(a);
		vb = sx12(b);
		vc = sx12(c);
		assertReset();
		clearProgram();
		emit(encI(3'b000, 5'd1, 5'd0, a, opImmCode));
		emit(encI(3'b000, 5'd2, 5'd0, b, opImmCode));
		emit(encR(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
		emit(encS(5'd3, 5'd0, 12'h100));
		emit(encR(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2));
		emit(encS(5'd4, 5'd0, 12'h104));
		emit(encR(7'b0000000, 3'b110, 5'd5, 5'd1, 5'd2));
		emit(encS(5'd5, 5'd0, 12'h108));
		emit(encR(7'b0000000, 3'b111, 5'd6, 5'd1, 5'd2));
		emit(encS(5'd6, 5'd0, 12'h10C));
		emit(encR(7'b0000000, 3'b010, 5'd7, 5'd1, 5'd2));
		emit(encS(5'd7, 5'd0, 12'h110));
		emit(encI(3'b110, 5'd8, 5'd1, c, opImmCode));
		emit(encS(5'd8, 5'd0, 12'h114));
		emit(encI(3'b111, 5'd9, 5'd1, c, opImmCode));
		emit(encS(5'd9, 5'd0, 12'h118));
		emit(encI(3'b010, 5'd10, 5'd1, c, opImmCode));
		emit(encS(5'd10, 5'd0, 12'h11C));
		endProgram();
		releaseReset();
		waitForStoreCount(sentinelAddr, 1, "arithmetic");
		expectStore(32'h100, va + vb);
		expectStore(32'h104, va - vb);
		expectStore(32'h108, va | vb);
		expectStore(32'h10C, va & vb);
		expectStore(32'h110, ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0);
		expectStore(32'h114, va | vc);
		expectStore(32'h118, va & vc);
		expectStore(32'h11C, ($signed(va) < $signed(vc)) ? 32'd1 : 32'd0);
	endtask

	// back-to-back chain, then a producer two slots ahead
	task automatic testForwarding();
		logic [11:0] k [4];
		logic [31:0] s2;
		logic [31:0] s3;
		logic [31:0] t;
		for (int i = 0; i < 4; i++)
			k[i] = rand12();
		s2 = sx12(k[0]) + sx12(k[1]);
		s3 = s2 + sx12(k[2]);
		t = sx12(k[3]) + s3;
		assertReset();
		clearProgram();
		emit(encI(3'b000, 5'd1, 5'd0, k[0], opImmCode));
		emit(encI(3'b000, 5'd1, 5'd1, k[1], opImmCode));
		emit(encS(5'd1, 5'd0, 12'h120));
		emit(encI(3'b000, 5'd1, 5'd1, k[2], opImmCode));
		emit(encS(5'd1, 5'd0, 12'h124));
		emit(encI(3'b000, 5'd2, 5'd0, k[3], opImmCode));
		emit(encI(3'b000, 5'd6, 5'd0, 12'd1, opImmCode));
		emit(encR(7'b0000000, 3'b000, 5'd3, 5'd2, 5'd1));
		emit(encS(5'd3, 5'd0, 12'h128));
		emit(encR(7'b0000000, 3'b000, 5'd4, 5'd3, 5'd1));
		emit(encS(5'd4, 5'd0, 12'h12C));
		endProgram();
		releaseReset();
		waitForStoreCount(sentinelAddr, 1, "forwarding");
		expectStore(32'h120, s2);
		expectStore(32'h124, s3);
		expectStore(32'h128, t);
		expectStore(32'h12C, t + s3);
	endtask

	// loaded value consumed by the very next instruction
	task automatic testLoadUse();
		logic [11:0] v;
		logic [11:0] c;
		logic [31:0] untouched;
		v = rand12();
		c = rand12();
		untouched = 32'h180;
		assertReset();
		clearProgram();
		emit(encI(3'b000, 5'd1, 5'd0, v, opImmCode));
		emit(encS(5'd1, 5'd0, 12'h140));
		emit(encI(3'b010, 5'd2, 5'd0, 12'h140, loadCode));
		emit(encI(3'b000, 5'd3, 5'd2, c, opImmCode));
		emit(encS(5'd3, 5'd0, 12'h144));
		emit(encI(3'b010, 5'd4, 5'd0, untouched[11:0], loadCode));
		emit(encR(7'b0000000, 3'b000, 5'd5, 5'd4, 5'd1));
		emit(encS(5'd5, 5'd0, 12'h148));
		endProgram();
		releaseReset();
		waitForStoreCount(sentinelAddr, 1, "load-use");
		expectStore(32'h144, sx12(v) + sx12(c));
		expectStore(32'h148, fillWord(untouched[9:2]) + sx12(v));
	endtask

	task automatic testBranchNotTaken();
		assertReset();
		clearProgram();
		emit(encI(3'b000, 5'd1, 5'd0, 12'd5, opImmCode));
		emit(encI(3'b000, 5'd2, 5'd0, 12'd6, opImmCode));
		emit(encB(5'd1, 5'd2, 13'd8));
		emit(encI(3'b000, 5'd3, 5'd0, 12'd77, opImmCode));
		emit(encS(5'd3, 5'd0, 12'h160));
		endProgram();
		releaseReset();
		waitForStoreCount(sentinelAddr, 1, "branch not taken");
		expectStore(32'h160, 32'd77);
	endtask

	// skipped slots hold stores that must never reach memory
	task automatic testBranchTaken();
		logic [11:0] r;
		logic [31:0] jalAddr;
		r = rand12();
		assertReset();
		clearProgram();
		emit(encI(3'b000, 5'd1, 5'd0, r, opImmCode));
		emit(encI(3'b000, 5'd2, 5'd1, 12'd0, opImmCode));
		emit(encB(5'd1, 5'd2, 13'd8));
		emit(encS(5'd1, 5'd0, 12'h170));
		emit(encI(3'b000, 5'd3, 5'd0, 12'd33, opImmCode));
		emit(encS(5'd3, 5'd0, 12'h174));
		// x7 sits in the memory stage when beq compares it
		emit(encI(3'b000, 5'd5, 5'd0, 12'd9, opImmCode));
		emit(encI(3'b000, 5'd7, 5'd0, 12'd9, opImmCode));
		emit(encI(3'b000, 5'd8, 5'd0, 12'd0, opImmCode));
		emit(encB(5'd5, 5'd7, 13'd8));
		emit(encS(5'd5, 5'd0, 12'h184));
		emit(encS(5'd7, 5'd0, 12'h188));
		jalAddr = progLen * 4;
		emit(encJ(5'd4, 21'd8));
		emit(encS(5'd1, 5'd0, 12'h178));
		emit(encS(5'd4, 5'd0, 12'h17C));
		endProgram();
		releaseReset();
		waitForStoreCount(sentinelAddr, 1, "branch taken");
		expectNoStore(32'h170);
		expectStore(32'h174, 32'd33);
		expectNoStore(32'h184);
		expectStore(32'h188, 32'd9);
		expectNoStore(32'h178);
		expectStore(32'h17C, jalAddr + 32'd4);
	endtask

	initial begin
		rst = 1'b1;
		errors = 0;
		checks = 0;
		logStart = 0;
		void'($urandom(10414));
		clearProgram();
		testReset();
		testArith();
		testForwarding();
		testLoadUse();
		testBranchNotTaken();
		testBranchTaken();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: rtl/decodeStage.sv
/*
 * decode stage
 * control decode, immediates, redirect targets, beq compare and register reads
 */
`timescale 1ns/100ps
`include "rvCore_defines.svh"

module decodeStage import rvCorePkg::*; (
	input  logic clk,
	input  logic [`RV_XLEN-1:0] instr,
	input  logic [`RV_XLEN-1:0] pc,
	input  logic [`RV_XLEN-1:0] pcPlus4,
	input  logic fwdBranchA,
	input  logic fwdBranchB,
	input  logic [`RV_XLEN-1:0] memAluResult,
	input  logic wbEn,
	input  logic [4:0] wbRd,
	input  logic [`RV_XLEN-1:0] wbData,
	output logic pcSrc,
	output logic jump,
	output logic [`RV_XLEN-1:0] branchTarget,
	output logic [`RV_XLEN-1:0] jumpTarget,
	output ctrlT ctrl,
	output logic [`RV_XLEN-1:0] srcA,
	output logic [`RV_XLEN-1:0] srcB,
	output logic [`RV_XLEN-1:0] imm,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic subBit;
	logic isBranch;
	logic usesRs1;
	logic usesRs2;
	logic [`RV_XLEN-1:0] immI;
	logic [`RV_XLEN-1:0] immS;
	logic [`RV_XLEN-1:0] immB;
	logic [`RV_XLEN-1:0] immJ;
	logic [`RV_XLEN-1:0] cmpA;
	logic [`RV_XLEN-1:0] cmpB;

	// funct3 to ALU op, sub only reachable from R-type
	function automatic aluOpT aluOpOf(input logic [2:0] f3, input logic sub);
		case (f3)
			3'b010: return aluSlt;
			3'b110: return aluOr;
			3'b111: return aluAnd;
			default: return sub ? aluSub : aluAdd;
		endcase
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign subBit = instr[30];

	// sign-extended immediate formats
	assign immI = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
	assign immS = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
		instr[11:8], 1'b0};
	assign immJ = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
		instr[30:21], 1'b0};

	// anything not listed stays all zero, i.e. a bubble
	always_comb begin
		ctrl = '0;
		isBranch = 1'b0;
		usesRs1 = 1'b0;
		usesRs2 = 1'b0;
		imm = immI;
		case (opcode)
			opOp: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluOpOf(funct3, subBit);
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
			end
			opOpImm: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluOpOf(funct3, 1'b0);
				usesRs1 = 1'b1;
			end
			opLoad: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
				usesRs1 = 1'b1;
			end
			opStore: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				imm = immS;
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
			end
			opBranch: begin
				isBranch = 1'b1;
				imm = immB;
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
			end
			opJal: begin
				ctrl.regWrite = 1'b1;
				ctrl.jump = 1'b1;
				imm = immJ;
			end
			default: begin
			end
		endcase
	end

	// unused fields read as x0 so the hazard unit never matches
	// on immediate bits
	assign rs1 = usesRs1 ? instr[19:15] : 5'd0;
	assign rs2 = usesRs2 ? instr[24:20] : 5'd0;
	assign rd = ctrl.regWrite ? instr[11:7] : 5'd0;

	regFile regs (
		.clk(clk),
		.rs1(rs1),
		.rs2(rs2),
		.wbEn(wbEn),
		.wbRd(wbRd),
		.wbData(wbData),
		.rd1(srcA),
		.rd2(srcB)
	);

	// early compare, memory-stage ALU result is the only bypass
	// writeback is covered by the register file write-through
	assign cmpA = fwdBranchA ? memAluResult : srcA;
	assign cmpB = fwdBranchB ? memAluResult : srcB;
	assign pcSrc = isBranch && (cmpA == cmpB);
	assign jump = ctrl.jump;

	// targets idle at the sequential address when not in use
	assign branchTarget = isBranch ? pc + immB : pcPlus4;
	assign jumpTarget = ctrl.jump ? pc + immJ : pcPlus4;

endmodule

// File: rtl/executeStage.sv
/*
 * execute stage
 * operand bypass muxes, immediate select and ALU
 */
`timescale 1ns/100ps
`include "rvCore_defines.svh"

module executeStage import rvCorePkg::*; (
	input  ctrlT ctrl,
	input  logic [`RV_XLEN-1:0] srcA,
	input  logic [`RV_XLEN-1:0] srcB,
	input  logic [`RV_XLEN-1:0] imm,
	input  logic [`RV_XLEN-1:0] pcPlus4,
	input  fwdSelT fwdA,
	input  fwdSelT fwdB,
	input  logic [`RV_XLEN-1:0] memAluResult,
	input  logic [`RV_XLEN-1:0] wbData,
	output logic [`RV_XLEN-1:0] aluResult,
	output logic [`RV_XLEN-1:0] writeData
);

	logic [`RV_XLEN-1:0] opA;
	logic [`RV_XLEN-1:0] opB;
	logic [`RV_XLEN-1:0] aluOut;

	// three-way operand source
	function automatic logic [`RV_XLEN-1:0] pickSrc(
		input fwdSelT sel,
		input logic [`RV_XLEN-1:0] regVal,
		input logic [`RV_XLEN-1:0] memVal,
		input logic [`RV_XLEN-1:0] wbVal
	);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = pickSrc(fwdA, srcA, memAluResult, wbData);

	// store data is the forwarded rs2, before the immediate mux
	assign writeData = pickSrc(fwdB, srcB, memAluResult, wbData);
	assign opB = ctrl.aluSrc ? imm : writeData;

	always_comb begin
		case (ctrl.aluOp)
			aluSub: aluOut = opA - opB;
			aluOr: aluOut = opA | opB;
			aluAnd: aluOut = opA & opB;
			// signed compare
			aluSlt: aluOut = {{(`RV_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			default: aluOut = opA + opB;
		endcase
	end

	// jal writes its link address through the ALU result path
	assign aluResult = ctrl.jump ? pcPlus4 : aluOut;

endmodule

// File: rtl/fetchUnit.sv
/*
 * fetch unit
 * program counter, next-PC select and sequential increment
 */
`timescale 1ns/100ps
`include "rvCore_defines.svh"

module fetchUnit (
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic pcSrc,
	input  logic jump,
	input  logic [`RV_XLEN-1:0] branchTarget,
	input  logic [`RV_XLEN-1:0] jumpTarget,
	output logic [`RV_XLEN-1:0] imemAddr,
	output logic [`RV_XLEN-1:0] pcPlus4
);

	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] nextPc;

	assign pcPlus4 = pc + `RV_XLEN'd4;
	assign imemAddr = pc;

	// both redirects come from decode
	// beq and jal never resolve together, so 2'b11 just falls through
	always_comb begin
		case ({pcSrc, jump})
			2'b01: nextPc = jumpTarget;
			2'b10: nextPc = branchTarget;
			default: nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= `RV_RESET_PC;
		else if (!stall)
			pc <= nextPc;
	end

endmodule

// File: rtl/hazardUnit.sv
/*
 * hazard unit
 * bypass selects for execute and beq, load-use and branch stalls, squashes
 */
`timescale 1ns/100ps

module hazardUnit import rvCorePkg::*; (
	input  logic [4:0] decRs1,
	input  logic [4:0] decRs2,
	input  logic decIsBranch,
	input  logic [4:0] exRs1,
	input  logic [4:0] exRs2,
	input  logic [4:0] exRd,
	input  logic exRegWrite,
	input  logic exMemToReg,
	input  logic [4:0] memRd,
	input  logic memRegWrite,
	input  logic memMemToReg,
	input  logic [4:0] wbRd,
	input  logic wbRegWrite,
	input  logic pcSrc,
	input  logic jump,
	output fwdSelT fwdA,
	output fwdSelT fwdB,
	output logic fwdBranchA,
	output logic fwdBranchB,
	output logic stallFetch,
	output logic stallDecode,
	output logic flushFetch,
	output logic flushDecode
);

	logic exHitsDec;
	logic memHitsDec;
	logic loadUse;
	logic branchStall;
	logic stall;

	// youngest producer wins
	function automatic fwdSelT pickFwd(input logic [4:0] rs);
		if (rs != 5'd0 && memRegWrite && rs == memRd)
			return fwdMem;
		else if (rs != 5'd0 && wbRegWrite && rs == wbRd)
			return fwdWb;
		else
			return fwdReg;
	endfunction

	assign fwdA = pickFwd(exRs1);
	assign fwdB = pickFwd(exRs2);

	// beq bypass from the memory stage, loads there stall instead
	assign fwdBranchA = decRs1 != 5'd0 && memRegWrite && !memMemToReg && decRs1 == memRd;
	assign fwdBranchB = decRs2 != 5'd0 && memRegWrite && !memMemToReg && decRs2 == memRd;

	// decode sources that match a later-stage destination
	assign exHitsDec = exRd != 5'd0 && (exRd == decRs1 || exRd == decRs2);
	assign memHitsDec = memRd != 5'd0 && (memRd == decRs1 || memRd == decRs2);

	assign loadUse = exMemToReg && exHitsDec;
	assign branchStall = decIsBranch && ((exRegWrite && exHitsDec) || (memMemToReg && memHitsDec));
	assign stall = loadUse || branchStall;

	// hold PC and fetch register, bubble into execute
	assign stallFetch = stall;
	assign stallDecode = stall;
	assign flushDecode = stall;

	// squash the slot fetched behind a taken redirect
	assign flushFetch = pcSrc || jump;

endmodule

// File: rtl/regFile.sv
/*
 * integer register file
 * two async reads, one write on the rising edge, x0 reads zero
 */
`timescale 1ns/100ps
`include "rvCore_defines.svh"

module regFile (
	input  logic clk,
	input  logic [4:0] rs1,
	input  logic [4:0] rs2,
	input  logic wbEn,
	input  logic [4:0] wbRd,
	input  logic [`RV_XLEN-1:0] wbData,
	output logic [`RV_XLEN-1:0] rd1,
	output logic [`RV_XLEN-1:0] rd2
);

	logic [`RV_XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (wbEn && wbRd != 5'd0)
			regs[wbRd] <= wbData;
	end

	// write-through so decode sees a value retiring this cycle
	assign rd1 = (rs1 == 5'd0) ? '0 : (wbEn && wbRd == rs1) ? wbData : regs[rs1];
	assign rd2 = (rs2 == 5'd0) ? '0 : (wbEn && wbRd == rs2) ? wbData : regs[rs2];

endmodule

// File: rtl/resultStage.sv
/*
 * memory and writeback
 * drives the data memory port, registers results, picks the writeback value
 */
`timescale 1ns/100ps
`include "rvCore_defines.svh"

module resultStage import rvCorePkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic regWrite,
	input  logic memToReg,
	input  logic memWrite,
	input  logic [`RV_XLEN-1:0] aluResult,
	input  logic [`RV_XLEN-1:0] writeData,
	input  logic [4:0] rd,
	input  logic [`RV_XLEN-1:0] dmemRdata,
	output logic [`RV_XLEN-1:0] dmemAddr,
	output logic [`RV_XLEN-1:0] dmemWdata,
	output logic dmemWe,
	output logic wbEn,
	output logic [4:0] wbRd,
	output logic [`RV_XLEN-1:0] wbData
);

	wbPayloadT wbD;
	wbPayloadT wbQ;

	// data memory reads combinationally and writes on the clock
	assign dmemAddr = aluResult;
	assign dmemWdata = writeData;
	assign dmemWe = memWrite;

	assign wbD = '{regWrite: regWrite, memToReg: memToReg, aluResult: aluResult,
		readData: dmemRdata, rd: rd};

	// nothing stalls or squashes this late
	stageReg #(
		.payloadT(wbPayloadT),
		.idleValue(wbIdle)
	) wbReg (
		.clk(clk),
		.rst(rst),
		.stall(1'b0),
		.flush(1'b0),
		.d(wbD),
		.q(wbQ)
	);

	assign wbEn = wbQ.regWrite;
	assign wbRd = wbQ.rd;
	assign wbData = wbQ.memToReg ? wbQ.readData : wbQ.aluResult;

endmodule

// File: rtl/rvCore.sv
/*
 * rvCore top
 * five-stage RV32I subset pipeline with external instruction and data memory
 */
`timescale 1ns/100ps
`include "rvCore_defines.svh"

module rvCore import rvCorePkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic [`RV_XLEN-1:0] imemData,
	input  logic [`RV_XLEN-1:0] dmemRdata,
	output logic [`RV_XLEN-1:0] imemAddr,
	output logic [`RV_XLEN-1:0] dmemAddr,
	output logic [`RV_XLEN-1:0] dmemWdata,
	output logic dmemWe
);

	fetchPayloadT fetchD;
	fetchPayloadT fetchQ;
	decPayloadT decD;
	decPayloadT decQ;
	exPayloadT exD;
	exPayloadT exQ;

	// fetch and redirect
	logic [`RV_XLEN-1:0] pcPlus4F;
	logic [`RV_XLEN-1:0] branchTarget;
	logic [`RV_XLEN-1:0] jumpTarget;
	logic pcSrc;
	logic jump;

	// decode outputs
	ctrlT ctrlD;
	logic [`RV_XLEN-1:0] srcAD;
	logic [`RV_XLEN-1:0] srcBD;
	logic [`RV_XLEN-1:0] immD;
	logic [4:0] rs1D;
	logic [4:0] rs2D;
	logic [4:0] rdD;
	logic decIsBranch;

	// hazard controls
	logic stallFetch;
	logic stallDecode;
	logic flushFetch;
	logic flushDecode;
	logic fwdBranchA;
	logic fwdBranchB;
	fwdSelT fwdA;
	fwdSelT fwdB;

	// execute and writeback
	logic [`RV_XLEN-1:0] aluResultE;
	logic [`RV_XLEN-1:0] writeDataE;
	logic wbEn;
	logic [4:0] wbRd;
	logic [`RV_XLEN-1:0] wbData;

	fetchUnit fetch (
		.clk(clk),
		.rst(rst),
		.stall(stallFetch),
		.pcSrc(pcSrc),
		.jump(jump),
		.branchTarget(branchTarget),
		.jumpTarget(jumpTarget),
		.imemAddr(imemAddr),
		.pcPlus4(pcPlus4F)
	);

	assign fetchD = '{instr: imemData, pc: imemAddr, pcPlus4: pcPlus4F};

	stageReg #(
		.payloadT(fetchPayloadT),
		.idleValue(fetchIdle)
	) fetchReg (
		.clk(clk),
		.rst(rst),
		.stall(stallDecode),
		.flush(flushFetch),
		.d(fetchD),
		.q(fetchQ)
	);

	decodeStage decode (
		.clk(clk),
		.instr(fetchQ.instr),
		.pc(fetchQ.pc),
		.pcPlus4(fetchQ.pcPlus4),
		.fwdBranchA(fwdBranchA),
		.fwdBranchB(fwdBranchB),
		.memAluResult(exQ.aluResult),
		.wbEn(wbEn),
		.wbRd(wbRd),
		.wbData(wbData),
		.pcSrc(pcSrc),
		.jump(jump),
		.branchTarget(branchTarget),
		.jumpTarget(jumpTarget),
		.ctrl(ctrlD),
		.srcA(srcAD),
		.srcB(srcBD),
		.imm(immD),
		.rs1(rs1D),
		.rs2(rs2D),
		.rd(rdD)
	);

	// opcode tap for the branch-operand stall
	assign decIsBranch = fetchQ.instr[6:0] == opBranch;

	assign decD = '{ctrl: ctrlD, srcA: srcAD, srcB: srcBD, imm: immD, rs1: rs1D,
		rs2: rs2D, rd: rdD, pcPlus4: fetchQ.pcPlus4};

	stageReg #(
		.payloadT(decPayloadT),
		.idleValue(decIdle)
	) decReg (
		.clk(clk),
		.rst(rst),
		.stall(1'b0),
		.flush(flushDecode),
		.d(decD),
		.q(decQ)
	);

	hazardUnit hazard (
		.decRs1(rs1D),
		.decRs2(rs2D),
		.decIsBranch(decIsBranch),
		.exRs1(decQ.rs1),
		.exRs2(decQ.rs2),
		.exRd(decQ.rd),
		.exRegWrite(decQ.ctrl.regWrite),
		.exMemToReg(decQ.ctrl.memToReg),
		.memRd(exQ.rd),
		.memRegWrite(exQ.regWrite),
		.memMemToReg(exQ.memToReg),
		.wbRd(wbRd),
		.wbRegWrite(wbEn),
		.pcSrc(pcSrc),
		.jump(jump),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.fwdBranchA(fwdBranchA),
		.fwdBranchB(fwdBranchB),
		.stallFetch(stallFetch),
		.stallDecode(stallDecode),
		.flushFetch(flushFetch),
		.flushDecode(flushDecode)
	);

	executeStage execute (
		.ctrl(decQ.ctrl),
		.srcA(decQ.srcA),
		.srcB(decQ.srcB),
		.imm(decQ.imm),
		.pcPlus4(decQ.pcPlus4),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.memAluResult(exQ.aluResult),
		.wbData(wbData),
		.aluResult(aluResultE),
		.writeData(writeDataE)
	);

	assign exD = '{regWrite: decQ.ctrl.regWrite, memToReg: decQ.ctrl.memToReg,
		memWrite: decQ.ctrl.memWrite, aluResult: aluResultE, writeData: writeDataE,
		rd: decQ.rd};

	stageReg #(
		.payloadT(exPayloadT),
		.idleValue(exIdle)
	) exReg (
		.clk(clk),
		.rst(rst),
		.stall(1'b0),
		.flush(1'b0),
		.d(exD),
		.q(exQ)
	);

	resultStage result (
		.clk(clk),
		.rst(rst),
		.regWrite(exQ.regWrite),
		.memToReg(exQ.memToReg),
		.memWrite(exQ.memWrite),
		.aluResult(exQ.aluResult),
		.writeData(exQ.writeData),
		.rd(exQ.rd),
		.dmemRdata(dmemRdata),
		.dmemAddr(dmemAddr),
		.dmemWdata(dmemWdata),
		.dmemWe(dmemWe),
		.wbEn(wbEn),
		.wbRd(wbRd),
		.wbData(wbData)
	);

endmodule

// File: rtl/rvCorePkg.sv
/*
 * rvCore shared types
 * ALU ops, decoded control, stage payloads and their idle values
 */
`include "rvCore_defines.svh"

package rvCorePkg;

	// base opcodes of the supported subset
	parameter logic [6:0] opLoad   = 7'b0000011;
	parameter logic [6:0] opOpImm  = 7'b0010011;
	parameter logic [6:0] opStore  = 7'b0100011;
	parameter logic [6:0] opOp     = 7'b0110011;
	parameter logic [6:0] opBranch = 7'b1100011;
	parameter logic [6:0] opJal    = 7'b1101111;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluOr  = 3'd2,
		aluAnd = 3'd3,
		aluSlt = 3'd4
	} aluOpT;

	// execute operand source, same encoding as the classic hazard unit
	typedef enum logic [1:0] {
		fwdReg = 2'b00,
		fwdWb  = 2'b01,
		fwdMem = 2'b10
	} fwdSelT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic jump;
		aluOpT aluOp;
	} ctrlT;

	// fetch -> decode
	typedef struct packed {
		logic [`RV_XLEN-1:0] instr;
		logic [`RV_XLEN-1:0] pc;
		logic [`RV_XLEN-1:0] pcPlus4;
	} fetchPayloadT;

	// decode -> execute
	typedef struct packed {
		ctrlT ctrl;
		logic [`RV_XLEN-1:0] srcA;
		logic [`RV_XLEN-1:0] srcB;
		logic [`RV_XLEN-1:0] imm;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [`RV_XLEN-1:0] pcPlus4;
	} decPayloadT;

	// execute -> memory
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic [`RV_XLEN-1:0] aluResult;
		logic [`RV_XLEN-1:0] writeData;
		logic [4:0] rd;
	} exPayloadT;

	// memory -> writeback
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic [`RV_XLEN-1:0] aluResult;
		logic [`RV_XLEN-1:0] readData;
		logic [4:0] rd;
	} wbPayloadT;

	// bubble contents per boundary
	// only the fetch slot needs a real instruction
	parameter fetchPayloadT fetchIdle = '{instr: `RV_NOP, default: '0};
	parameter decPayloadT decIdle = '0;
	parameter exPayloadT exIdle = '0;
	parameter wbPayloadT wbIdle = '0;

endpackage

// File: rtl/stageReg.sv
/*
 * pipeline stage register
 * holds on stall, drops to a bubble on reset or flush
 */
`timescale 1ns/100ps

module stageReg #(
	parameter type payloadT = logic [31:0],
	parameter payloadT idleValue = '0
) (
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic flush,
	input  payloadT d,
	output payloadT q
);

	// stall takes priority over flush
	always_ff @(posedge clk) begin
		if (rst)
			q <= idleValue;
		else if (stall)
			q <= q;
		else if (flush)
			q <= idleValue;
		else
			q <= d;
	end

endmodule

// File: run.sh
#!/bin/sh
# build the rvCore testbench with Verilator, run it, then judge the log
rm -f sim.log
verilator --binary --assert --timescale 1ns/100ps --top-module rvCoreTb -f rvCore.f \
	-o rvCoreSim && ./obj_dir/rvCoreSim > sim.log 2>&1 || echo "build or simulation failed"
[ -f sim.log ] && cat sim.log
grep -q "Result: PASSED" sim.log 2>/dev/null && exit 0 || exit 1

// File: rvCore.f
+incdir+.
rtl/rvCorePkg.sv
rtl/stageReg.sv
rtl/fetchUnit.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/resultStage.sv
rtl/rvCore.sv
bench/rvCoreTb.sv

// File: rvCore_defines.svh
/*
 * rvCore global parameters
 * datapath width, reset vector and the squash instruction
 */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// datapath and register width
`define RV_XLEN 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
// loaded into the fetch register when a slot is squashed
`define RV_NOP 32'h0000_0013

`endif
